// ==== logic/uart_axi_pkg.sv ====
`default_nettype none

package uart_axi_pkg;

    // ##########################################################################
    // bus and line widths
    // ##########################################################################

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    typedef logic [7:0]  uart_byte_t;
    typedef logic [15:0] baud_div_t;

    // ##########################################################################
    // response codes and register map
    // ##########################################################################

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    localparam axi_addr_t REG_TXDATA  = 32'h0000_0000;
    localparam axi_addr_t REG_DIVISOR = 32'h0000_0004;

    // the peripheral base is decoded upstream, so only the low nibble matters here.
    localparam axi_addr_t ADDR_OFFSET_MASK = 32'h0000_000F;

endpackage

`default_nettype wire

// ==== logic/axi_uart_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_uart_slave
    import uart_axi_pkg::*;
#(
    parameter baud_div_t RESET_DIVISOR = 16'd4
) (
    input  wire             aclk,
    input  wire             areset_n,

    input  wire             axi_uart_aw_valid_i,
    input  wire axi_addr_t  axi_uart_aw_addr_i,
    output logic            axi_uart_aw_ready_o,

    input  wire             axi_uart_w_valid_i,
    input  wire axi_strb_t  axi_uart_w_strb_i,
    input  wire axi_data_t  axi_uart_w_data_i,
    output logic            axi_uart_w_ready_o,

    output axi_resp_t       axi_uart_b_resp_o,
    output logic            axi_uart_b_valid_o,
    input  wire             axi_uart_b_ready_i,

    input  wire             fifo_full_i,
    output logic            fifo_push_o,
    output uart_byte_t      fifo_push_data_o,
    output baud_div_t       divisor_o
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } uart_wr_state_t;

    uart_wr_state_t state_q;

    axi_addr_t  addr_q;
    axi_addr_t  offset;
    axi_resp_t  resp_q;
    baud_div_t  divisor_q;

    logic       aw_xfer;
    logic       w_xfer;
    logic       b_xfer;
    logic       sel_txdata;
    logic       sel_divisor;

    // ##########################################################################
    // handshakes
    // ##########################################################################

    // each channel is open in exactly one state, so the three never overlap.
    assign axi_uart_aw_ready_o = (state_q == ADDR);
    assign axi_uart_w_ready_o  = (state_q == DATA) && !fifo_full_i;
    assign axi_uart_b_valid_o  = (state_q == RESP);
    assign axi_uart_b_resp_o   = resp_q;

    assign aw_xfer = axi_uart_aw_valid_i && axi_uart_aw_ready_o;
    assign w_xfer  = axi_uart_w_valid_i && axi_uart_w_ready_o;
    assign b_xfer  = axi_uart_b_valid_o && axi_uart_b_ready_i;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    state_q <= ADDR;
                end
                ADDR: begin
                    if (aw_xfer) begin
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (w_xfer) begin
                        state_q <= RESP;
                    end
                end
                RESP: begin
                    if (b_xfer) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_xfer) begin
            addr_q <= axi_uart_aw_addr_i;
        end
    end

    // ##########################################################################
    // register decode
    // ##########################################################################

    assign offset      = addr_q & ADDR_OFFSET_MASK;
    assign sel_txdata  = (offset == REG_TXDATA);
    assign sel_divisor = (offset == REG_DIVISOR);

    // a byte is queued only on the data beat itself, and only with lane 0 enabled.
    assign fifo_push_o      = w_xfer && sel_txdata && axi_uart_w_strb_i[0];
    assign fifo_push_data_o = axi_uart_w_data_i[7:0];

    always_ff @(posedge aclk) begin
        if (w_xfer) begin
            resp_q <= (sel_txdata || sel_divisor) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            divisor_q <= RESET_DIVISOR;
        end else if (w_xfer && sel_divisor) begin
            if (axi_uart_w_strb_i[0]) begin
                divisor_q[7:0] <= axi_uart_w_data_i[7:0];
            end
            if (axi_uart_w_strb_i[1]) begin
                divisor_q[15:8] <= axi_uart_w_data_i[15:8];
            end
        end
    end

    assign divisor_o = divisor_q;

endmodule

`default_nettype wire

// ==== logic/uart_tx_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx_fifo
    import uart_axi_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  wire             aclk,
    input  wire             areset_n,

    input  wire             push_i,
    input  wire uart_byte_t push_data_i,
    output logic            full_o,

    input  wire             pop_i,
    output uart_byte_t      pop_data_o,
    output logic            empty_o
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    uart_byte_t                 mem_q [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_q;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q;
    logic [FIFO_DEPTH_LOG2:0]   count_q;
    logic                       do_push;
    logic                       do_pop;

    // the count only reaches its top bit when every slot is occupied.
    assign full_o  = count_q[FIFO_DEPTH_LOG2];
    assign empty_o = (count_q == '0);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // head of the queue is always visible at the output.
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_tx_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx_serializer
    import uart_axi_pkg::*;
(
    input  wire             aclk,
    input  wire             areset_n,

    input  wire baud_div_t  divisor_i,

    input  wire             empty_i,
    input  wire uart_byte_t data_i,
    output logic            pop_o,

    output logic            uart_tx_o
);

    localparam int        FRAME_BITS = 10;
    localparam baud_div_t MIN_DIV    = 16'd2;

    logic                  busy_q;
    logic [FRAME_BITS-1:0] shift_q;
    logic [3:0]            bit_cnt_q;
    baud_div_t             period_cnt_q;
    baud_div_t             div_q;
    baud_div_t             div_clamped;
    logic                  bit_done;
    logic                  frame_done;

    assign div_clamped = (divisor_i < MIN_DIV) ? MIN_DIV : divisor_i;

    assign bit_done   = busy_q && (period_cnt_q == div_q - 16'd1);
    assign frame_done = bit_done && (bit_cnt_q == 4'(FRAME_BITS - 1));

    // the next byte is taken in the last cycle of a stop bit, so frames run back to back.
    assign pop_o = !empty_i && (!busy_q || frame_done);

    // ones shift in behind the stop bit, which leaves the line idle high.
    assign uart_tx_o = shift_q[0];

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            busy_q       <= 1'b0;
            shift_q      <= '1;
            bit_cnt_q    <= '0;
            period_cnt_q <= '0;
        end else if (pop_o) begin
            busy_q       <= 1'b1;
            shift_q      <= {1'b1, data_i, 1'b0};
            bit_cnt_q    <= '0;
            period_cnt_q <= '0;
        end else if (bit_done) begin
            shift_q      <= {1'b1, shift_q[FRAME_BITS-1:1]};
            bit_cnt_q    <= bit_cnt_q + 4'd1;
            period_cnt_q <= '0;
            if (frame_done) begin
                busy_q <= 1'b0;
            end
        end else if (busy_q) begin
            period_cnt_q <= period_cnt_q + 16'd1;
        end
    end

    // a divisor change only takes effect on the next frame.
    always_ff @(posedge aclk) begin
        if (pop_o) begin
            div_q <= div_clamped;
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_axi_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_axi_top
    import uart_axi_pkg::*;
#(
    parameter int        FIFO_DEPTH_LOG2 = 3,
    parameter baud_div_t RESET_DIVISOR   = 16'd4
) (
    input  wire             aclk,
    input  wire             areset_n,

    input  wire             axi_uart_aw_valid_i,
    input  wire axi_addr_t  axi_uart_aw_addr_i,
    output logic            axi_uart_aw_ready_o,

    input  wire             axi_uart_w_valid_i,
    input  wire axi_strb_t  axi_uart_w_strb_i,
    input  wire axi_data_t  axi_uart_w_data_i,
    output logic            axi_uart_w_ready_o,

    output axi_resp_t       axi_uart_b_resp_o,
    output logic            axi_uart_b_valid_o,
    input  wire             axi_uart_b_ready_i,

    output logic            uart_tx_o
);

    logic       fifo_full;
    logic       fifo_push;
    uart_byte_t fifo_push_data;
    logic       fifo_empty;
    logic       fifo_pop;
    uart_byte_t fifo_pop_data;
    baud_div_t  divisor;

    axi_uart_slave #(
        .RESET_DIVISOR (RESET_DIVISOR)
    ) u_slave (
        .aclk                (aclk),
        .areset_n            (areset_n),
        .axi_uart_aw_valid_i (axi_uart_aw_valid_i),
        .axi_uart_aw_addr_i  (axi_uart_aw_addr_i),
        .axi_uart_aw_ready_o (axi_uart_aw_ready_o),
        .axi_uart_w_valid_i  (axi_uart_w_valid_i),
        .axi_uart_w_strb_i   (axi_uart_w_strb_i),
        .axi_uart_w_data_i   (axi_uart_w_data_i),
        .axi_uart_w_ready_o  (axi_uart_w_ready_o),
        .axi_uart_b_resp_o   (axi_uart_b_resp_o),
        .axi_uart_b_valid_o  (axi_uart_b_valid_o),
        .axi_uart_b_ready_i  (axi_uart_b_ready_i),
        .fifo_full_i         (fifo_full),
        .fifo_push_o         (fifo_push),
        .fifo_push_data_o    (fifo_push_data),
        .divisor_o           (divisor)
    );

    uart_tx_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .push_i      (fifo_push),
        .push_data_i (fifo_push_data),
        .full_o      (fifo_full),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_pop_data),
        .empty_o     (fifo_empty)
    );

    uart_tx_serializer u_serializer (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .divisor_i (divisor),
        .empty_i   (fifo_empty),
        .data_i    (fifo_pop_data),
        .pop_o     (fifo_pop),
        .uart_tx_o (uart_tx_o)
    );

endmodule

`default_nettype wire

// ==== bench/uart_tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tb_clock #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic aclk,
    output logic areset_n
);

    initial begin
        aclk = 1'b0;
        forever begin
            #HALF_PERIOD aclk = ~aclk;
        end
    end

    // reset is released on a rising edge, like every other DUT input.
    initial begin
        areset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        areset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/uart_tb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tb_checker
    import uart_axi_pkg::*;
(
    input wire            aclk,
    input wire            areset_n,
    input wire            aw_ready_i,
    input wire            w_ready_i,
    input wire            b_valid_i,
    input wire            b_ready_i,
    input wire axi_resp_t b_resp_i,
    input wire            fifo_full_i,
    input wire            uart_tx_i
);

    // number of properties that have failed so far.
    int unsigned assert_errors = 0;

    a_b_held: assert property (@(posedge aclk) disable iff (!areset_n)
        b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
    else begin
        $error("b_valid dropped or b_resp changed before b_ready");
        assert_errors++;
    end

    a_one_channel: assert property (@(posedge aclk) disable iff (!areset_n)
        $onehot0({aw_ready_i, w_ready_i, b_valid_i}))
    else begin
        $error("more than one of aw_ready, w_ready and b_valid is high");
        assert_errors++;
    end

    a_full_stall: assert property (@(posedge aclk) disable iff (!areset_n)
        w_ready_i |-> !fifo_full_i)
    else begin
        $error("w_ready is high while the FIFO is full");
        assert_errors++;
    end

    a_line_idle: assert property (@(posedge aclk)
        $rose(areset_n) |-> uart_tx_i)
    else begin
        $error("serial line is not idle high after reset");
        assert_errors++;
    end

endmodule

bind uart_axi_top uart_tb_checker u_checker (
    .aclk        (aclk),
    .areset_n    (areset_n),
    .aw_ready_i  (axi_uart_aw_ready_o),
    .w_ready_i   (axi_uart_w_ready_o),
    .b_valid_i   (axi_uart_b_valid_o),
    .b_ready_i   (axi_uart_b_ready_i),
    .b_resp_i    (axi_uart_b_resp_o),
    .fifo_full_i (fifo_full),
    .uart_tx_i   (uart_tx_o)
);

`default_nettype wire

// ==== bench/uart_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tb
    import uart_axi_pkg::*;
();

    localparam int        FIFO_LOG2 = 2;
    localparam baud_div_t RESET_DIV = 16'd4;

    typedef struct packed {
        axi_addr_t addr;
        axi_strb_t strb;
        axi_data_t data;
        axi_resp_t resp;
    } wr_entry_t;

    wire        aclk;
    wire        areset_n;
    wire        aw_ready;
    wire        w_ready;
    wire        b_valid;
    wire        uart_tx;
    axi_resp_t  b_resp;

    logic       aw_valid;
    axi_addr_t  aw_addr;
    logic       w_valid;
    axi_strb_t  w_strb;
    axi_data_t  w_data;
    logic       b_ready;

    wr_entry_t   wr_table [$];
    uart_byte_t  expected_bytes [$];
    baud_div_t   model_div = RESET_DIV;
    int unsigned lcg_state = 24382;
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    uart_tb_clock u_clock (
        .aclk     (aclk),
        .areset_n (areset_n)
    );

    uart_axi_top #(
        .FIFO_DEPTH_LOG2 (FIFO_LOG2),
        .RESET_DIVISOR   (RESET_DIV)
    ) UUT (
        .aclk                (aclk),
        .areset_n            (areset_n),
        .axi_uart_aw_valid_i (aw_valid),
        .axi_uart_aw_addr_i  (aw_addr),
        .axi_uart_aw_ready_o (aw_ready),
        .axi_uart_w_valid_i  (w_valid),
        .axi_uart_w_strb_i   (w_strb),
        .axi_uart_w_data_i   (w_data),
        .axi_uart_w_ready_o  (w_ready),
        .axi_uart_b_resp_o   (b_resp),
        .axi_uart_b_valid_o  (b_valid),
        .axi_uart_b_ready_i  (b_ready),
        .uart_tx_o           (uart_tx)
    );

    // ##########################################################################
    // reference model and helpers
    // ##########################################################################

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned clamp_div(input baud_div_t div);
        return (div < 16'd2) ? 2 : int'(div);
    endfunction

    function automatic logic queues_byte(input wr_entry_t e);
        return ((e.addr & ADDR_OFFSET_MASK) == REG_TXDATA) && e.strb[0];
    endfunction

    function automatic baud_div_t next_divisor(input baud_div_t cur, input wr_entry_t e);
        baud_div_t result;
        result = cur;
        if ((e.addr & ADDR_OFFSET_MASK) == REG_DIVISOR) begin
            if (e.strb[0]) begin
                result[7:0] = e.data[7:0];
            end
            if (e.strb[1]) begin
                result[15:8] = e.data[15:8];
            end
        end
        return result;
    endfunction

    // entries x 20 for the bus, plus every frame twice over at the slowest divisor.
    function automatic int unsigned run_limit();
        baud_div_t   div;
        int unsigned max_div;
        int unsigned n_bytes;
        div = RESET_DIV;
        max_div = clamp_div(div);
        n_bytes = 0;
        foreach (wr_table[i]) begin
            if (queues_byte(wr_table[i])) begin
                n_bytes++;
            end
            div = next_divisor(div, wr_table[i]);
            if (clamp_div(div) > max_div) begin
                max_div = clamp_div(div);
            end
        end
        return wr_table.size() * 20 + n_bytes * 10 * max_div * 2;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_resp(input axi_resp_t expected, input axi_resp_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("mismatch axi_uart_b_resp_o: expected 0x%h, got 0x%h",
                                    expected, actual));
        end
    endtask

    task automatic check_byte(input uart_byte_t expected, input uart_byte_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("mismatch uart_tx_o byte: expected 0x%h, got 0x%h",
                                    expected, actual));
        end
    endtask

    task automatic add_entry(input axi_addr_t addr, input axi_strb_t strb,
                             input axi_data_t data, input axi_resp_t resp);
        wr_table.push_back('{addr, strb, data, resp});
    endtask

    task automatic load_table();
        add_entry(REG_TXDATA, 4'h1, 32'h0000_0055, RESP_OKAY);
        add_entry(REG_TXDATA, 4'hF, 32'hDEAD_BEA3, RESP_OKAY);
        add_entry(REG_TXDATA, 4'hE, 32'h0000_0077, RESP_OKAY);
        add_entry(32'h0000_0008, 4'hF, 32'h0000_0012, RESP_SLVERR);
        add_entry(REG_TXDATA, 4'h1, 32'h0000_003C, RESP_OKAY);
        add_entry(REG_DIVISOR, 4'h3, 32'h0000_0006, RESP_OKAY);
        add_entry(REG_TXDATA, 4'h1, 32'h0000_00C5, RESP_OKAY);
        add_entry(REG_TXDATA, 4'h1, 32'h0000_000F, RESP_OKAY);
        add_entry(32'h0000_000C, 4'h3, 32'h0000_0002, RESP_SLVERR);
        add_entry(REG_TXDATA, 4'h1, 32'h0000_00F0, RESP_OKAY);
        // only lane 0 is written, which leaves a divisor of 1.
        add_entry(REG_DIVISOR, 4'h1, 32'hFFFF_FF01, RESP_OKAY);
        add_entry(REG_TXDATA, 4'h1, 32'h0000_0081, RESP_OKAY);
        add_entry(REG_DIVISOR, 4'h3, 32'h0000_0005, RESP_OKAY);
        for (int i = 0; i < 10; i++) begin
            add_entry((i == 0) ? 32'h8000_0000 : REG_TXDATA, 4'h1,
                      32'((i * 37 + 5) & 8'hFF), RESP_OKAY);
        end
    endtask

    task automatic wait_drain();
        while (expected_bytes.size() != 0) begin
            @(negedge aclk);
        end
    endtask

    // ##########################################################################
    // AXI write master
    // ##########################################################################

    task automatic apply_write(input wr_entry_t e);
        int unsigned delay;
        @(posedge aclk);
        aw_valid <= 1'b1;
        aw_addr  <= e.addr;
        do begin
            @(negedge aclk);
        end while (!aw_ready);
        @(posedge aclk);
        aw_valid <= 1'b0;
        w_valid  <= 1'b1;
        w_strb   <= e.strb;
        w_data   <= e.data;
        do begin
            @(negedge aclk);
        end while (!w_ready);
        @(posedge aclk);
        w_valid <= 1'b0;
        if (queues_byte(e)) begin
            expected_bytes.push_back(e.data[7:0]);
        end
        model_div = next_divisor(model_div, e);
        delay = next_rand() >> 29;
        repeat (delay) @(posedge aclk);
        b_ready <= 1'b1;
        do begin
            @(negedge aclk);
        end while (!b_valid);
        check_resp(e.resp, b_resp);
        @(posedge aclk);
        b_ready <= 1'b0;
    endtask

    initial begin
        int unsigned idle_cycles;
        aw_valid <= 1'b0;
        aw_addr  <= '0;
        w_valid  <= 1'b0;
        w_strb   <= '0;
        w_data   <= '0;
        b_ready  <= 1'b0;
        load_table();
        cycle_limit = run_limit();
        wait (areset_n === 1'b1);
        foreach (wr_table[i]) begin
            // the decoder relies on no frame being in flight across a divisor change.
            if ((wr_table[i].addr & ADDR_OFFSET_MASK) == REG_DIVISOR) begin
                wait_drain();
            end
            apply_write(wr_table[i]);
        end
        idle_cycles = 0;
        while (idle_cycles < 12 * clamp_div(model_div)) begin
            @(negedge aclk);
            idle_cycles = (uart_tx === 1'b1) ? idle_cycles + 1 : 0;
        end
        if (UUT.u_checker.assert_errors != 0) begin
            stop_on_error("a bound assertion on the DUT failed");
        end else if (expected_bytes.size() != 0) begin
            stop_on_error($sformatf("%0d queued bytes never appeared on the serial line",
                                    expected_bytes.size()));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // ##########################################################################
    // serial line decoder and watchdog
    // ##########################################################################

    initial begin
        int unsigned bit_div;
        uart_byte_t  rx_byte;
        wait (areset_n === 1'b1);
        forever begin
            @(negedge aclk);
            if (uart_tx === 1'b0) begin
                bit_div = clamp_div(model_div);
                repeat (bit_div / 2) @(negedge aclk);
                for (int k = 0; k < 8; k++) begin
                    repeat (bit_div) @(negedge aclk);
                    rx_byte[k] = uart_tx;
                end
                repeat (bit_div) @(negedge aclk);
                if (uart_tx !== 1'b1) begin
                    stop_on_error("stop bit of a received frame was not high");
                end
                if (expected_bytes.size() == 0) begin
                    stop_on_error("a frame arrived on the serial line with no byte queued");
                end
                check_byte(expected_bytes.pop_front(), rx_byte);
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_on_error($sformatf("timeout after %0d cycles", cycle_limit));
        end
        if (UUT.u_checker.assert_errors != 0) begin
            stop_on_error("a bound assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/uart_axi_pkg.sv
logic/axi_uart_slave.sv
logic/uart_tx_fifo.sv
logic/uart_tx_serializer.sv
logic/uart_axi_top.sv
bench/uart_tb_clock.sv
bench/uart_tb_checker.sv
bench/uart_tb.sv
